/* rtl/mcast_pkg.sv */
package mcast_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int DATA_WIDTH  = 16;                    // Ifmap and filter words
    localparam int PSUM_WIDTH  = 32;                    // Partial sums
    localparam int NUM_COL     = 4;                     // PE columns on the bus
    localparam int ID_WIDTH    = $clog2(NUM_COL) + 1;   // One spare bit on top
    localparam int MAX_KERNEL  = 16;                    // Weight memory depth
    localparam int KSIZE_WIDTH = $clog2(MAX_KERNEL) + 1; // Holds 1..16
    localparam int ADDR_WIDTH  = $clog2(MAX_KERNEL);    // Tap index / weight address

    ////////////////////////////////////////
    // Opcodes and states
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        OP_NONE         = 3'd0,
        OP_FLUSH_TAG    = 3'd1,  // Data holds new tag
        OP_FLUSH_KERNEL = 3'd2,  // Data holds kernel size
        OP_FLTR         = 3'd3,  // One weight
        OP_IFMAP        = 3'd4,  // One ifmap word
        OP_PSUM         = 3'd5   // Partial sum, sign-extended on use
    } bus_op_e;

    typedef enum logic [1:0] {
        S_UNCONF = 2'd0,         // No kernel yet
        S_LOAD   = 2'd1,         // Taking filter words
        S_RUN    = 2'd2          // Multicasting ifmap words
    } cast_state_e;

    ////////////////////////////////////////
    // Packets
    ////////////////////////////////////////
    typedef struct packed {
        bus_op_e               op;
        logic [ID_WIDTH-1:0]   id;    // Destination column
        logic [DATA_WIDTH-1:0] data;
    } bus_pkt_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   tag;   // Source slot
        logic [PSUM_WIDTH-1:0] psum;
    } result_pkt_t;

endpackage

/* rtl/tag_buffer.sv */
`timescale 1ns/1ns

module tag_buffer (
    input  logic                           clk,
    input  logic                           rstn,
    input  mcast_pkg::bus_pkt_t            bus_in,
    output logic [mcast_pkg::ID_WIDTH-1:0] tag,
    output logic                           tag_lock,
    output logic                           id_match
);

    logic flush_tag;

    // Flush-tag ignores the packet ID
    assign flush_tag = (bus_in.op == mcast_pkg::OP_FLUSH_TAG);

    // Lock stays up until the next reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tag_lock <= 1'b0;
        end else if (flush_tag) begin
            tag_lock <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (flush_tag) begin
            tag <= bus_in.data[mcast_pkg::ID_WIDTH-1:0]; // Low bits carry the tag
        end
    end

    // Only a locked slot can match
    assign id_match = tag_lock && (bus_in.id == tag);

endmodule

/* rtl/weight_buffer.sv */
`timescale 1ns/1ns

module weight_buffer (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             wr_en,
    input  logic [mcast_pkg::DATA_WIDTH-1:0] wr_data,
    input  logic [mcast_pkg::ADDR_WIDTH-1:0] addr,
    input  logic                             rd_en,
    output logic [mcast_pkg::DATA_WIDTH-1:0] weight
);

    ////////////////////////////////////////
    // Kernel storage
    ////////////////////////////////////////

    // One word per tap
    logic [mcast_pkg::DATA_WIDTH-1:0] mem [mcast_pkg::MAX_KERNEL];

    // Loaded in tap order while the FSM sits in S_LOAD
    // addr walks 0..kernel_size-1 from the tap counter
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Tap read
    ////////////////////////////////////////

    // Registered read, lines up with the ifmap
    // word captured in mac_accum stage 1
    // Holds its value between taps
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            weight <= '0;
        end else if (rd_en) begin
            weight <= mem[addr];     // Weight for the current tap
        end
    end

endmodule

/* rtl/tap_counter.sv */
`timescale 1ns/1ns

module tap_counter (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [mcast_pkg::KSIZE_WIDTH-1:0] kernel_size,
    input  logic                              restart,
    input  logic                              step,
    output logic [mcast_pkg::ADDR_WIDTH-1:0]  tap_idx,
    output logic                              last_tap
);

    logic [mcast_pkg::KSIZE_WIDTH-1:0] tap_ext;

    assign tap_ext = {1'b0, tap_idx};  // Same width as kernel_size

    // Size 0 gives all ones here, so never a last tap
    assign last_tap = (tap_ext == kernel_size - 1'b1);

    // Shared by the load phase and the run phase
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tap_idx <= '0;
        end else if (restart) begin
            tap_idx <= '0;             // New kernel
        end else if (step) begin
            if (last_tap) begin
                tap_idx <= '0;         // Wrap for next window
            end else begin
                tap_idx <= tap_idx + 1'b1;
            end
        end
    end

endmodule

/* rtl/cast_fsm.sv */
`timescale 1ns/1ns

module cast_fsm (
    input  logic                              clk,
    input  logic                              rstn,
    input  mcast_pkg::bus_pkt_t               bus_in,
    input  logic                              id_match,
    input  logic                              tag_lock,
    input  logic                              last_tap,
    output logic [mcast_pkg::KSIZE_WIDTH-1:0] kernel_size,
    output logic                              load_en,
    output logic                              tap_en,
    output logic                              cnt_restart,
    output logic                              pe_ready
);

    mcast_pkg::cast_state_e state;
    mcast_pkg::cast_state_e state_nxt;
    logic                   flush_kernel;
    logic                   fltr_hit;
    logic                   ifmap_hit;

    ////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////
    assign flush_kernel = (bus_in.op == mcast_pkg::OP_FLUSH_KERNEL); // Any ID
    assign fltr_hit     = id_match && (bus_in.op == mcast_pkg::OP_FLTR);
    assign ifmap_hit    = id_match && (bus_in.op == mcast_pkg::OP_IFMAP);

    // Counter back to tap 0 on a new kernel
    assign cnt_restart = flush_kernel;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            kernel_size <= '0;
        end else if (flush_kernel) begin
            kernel_size <= bus_in.data[mcast_pkg::KSIZE_WIDTH-1:0];
        end
    end

    ////////////////////////////////////////
    // State machine
    ////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        if (flush_kernel) begin
            state_nxt = mcast_pkg::S_LOAD;   // Also aborts an open window
        end else begin
            case (state)
                mcast_pkg::S_LOAD: begin
                    // Last weight written
                    if (load_en && last_tap) begin
                        state_nxt = mcast_pkg::S_RUN;
                    end
                end
                mcast_pkg::S_RUN:    state_nxt = mcast_pkg::S_RUN;
                default:             state_nxt = mcast_pkg::S_UNCONF;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= mcast_pkg::S_UNCONF;
        end else begin
            state <= state_nxt;
        end
    end

    // Outputs
    assign load_en  = (state == mcast_pkg::S_LOAD) && fltr_hit;
    assign pe_ready = (state == mcast_pkg::S_RUN) && tag_lock;
    assign tap_en   = pe_ready && ifmap_hit;    // Multicast into the datapath

endmodule

/* rtl/mac_accum.sv */
`timescale 1ns/1ns

module mac_accum (
    input  logic                             clk,
    input  logic                             rstn,
    input  mcast_pkg::bus_pkt_t              bus_in,
    input  logic                             id_match,
    input  logic                             tap_en,
    input  logic                             last_tap,
    input  logic [mcast_pkg::DATA_WIDTH-1:0] weight,
    input  logic [mcast_pkg::ID_WIDTH-1:0]   tag,
    output logic                             result_valid,
    output mcast_pkg::result_pkt_t           result
);

    localparam int EXT = mcast_pkg::PSUM_WIDTH - mcast_pkg::DATA_WIDTH;

    logic                                   configured;  // Seen a flush-kernel
    logic                                   in_window;   // Window open
    logic                                   first_tap;
    logic                                   psum_hit;
    logic                                   seed_vld;
    logic signed [mcast_pkg::PSUM_WIDTH-1:0] seed_q;
    // Stage 1
    logic                                   v1, l1, f1;
    logic signed [mcast_pkg::DATA_WIDTH-1:0] ifmap_q;
    logic signed [mcast_pkg::PSUM_WIDTH-1:0] base1;
    // Stage 2
    logic                                   v2, l2, f2;
    logic signed [mcast_pkg::PSUM_WIDTH-1:0] prod_q;
    logic signed [mcast_pkg::PSUM_WIDTH-1:0] base2;
    // Accumulator
    logic signed [mcast_pkg::PSUM_WIDTH-1:0] acc_q;

    ////////////////////////////////////////
    // Window tracking and psum seed
    ////////////////////////////////////////
    assign first_tap = !in_window;
    assign psum_hit  = configured && id_match && (bus_in.op == mcast_pkg::OP_PSUM);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            configured <= 1'b0;
            in_window  <= 1'b0;
            seed_vld   <= 1'b0;
        end else begin
            if (bus_in.op == mcast_pkg::OP_FLUSH_KERNEL) begin
                configured <= 1'b1;
                in_window  <= 1'b0;               // Drop the open window
            end else if (tap_en) begin
                in_window <= !last_tap;
            end
            if (psum_hit) begin
                seed_vld <= 1'b1;
            end else if (tap_en && first_tap) begin
                seed_vld <= 1'b0;                 // Used by this window only
            end
        end
    end

    always_ff @(posedge clk) begin
        if (psum_hit) begin
            seed_q <= {{EXT{bus_in.data[mcast_pkg::DATA_WIDTH-1]}}, bus_in.data};
        end
    end

    ////////////////////////////////////////
    // Pipeline flags
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            v1           <= 1'b0;
            l1           <= 1'b0;
            f1           <= 1'b0;
            v2           <= 1'b0;
            l2           <= 1'b0;
            f2           <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            v1           <= tap_en;              // Beside the weight read
            l1           <= tap_en && last_tap;
            f1           <= tap_en && first_tap;
            v2           <= v1;
            l2           <= l1;
            f2           <= f1;
            result_valid <= v2 && l2;            // One-cycle pulse
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (tap_en) begin
            ifmap_q <= bus_in.data;
            base1   <= (first_tap && seed_vld) ? seed_q : '0; // Window start value
        end
        if (v1) begin
            prod_q <= ifmap_q * $signed(weight);  // Signed product
            base2  <= base1;
        end
        if (v2) begin
            acc_q <= (f2 ? base2 : acc_q) + prod_q;
        end
    end

    assign result = '{tag: tag, psum: acc_q};

endmodule

/* rtl/pe_multicast_top.sv */
`timescale 1ns/1ns

module pe_multicast_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  mcast_pkg::bus_pkt_t    bus_in,
    output logic                   result_valid,
    output mcast_pkg::result_pkt_t result,
    output logic                   tag_lock,
    output logic                   pe_ready
);

    logic [mcast_pkg::ID_WIDTH-1:0]    tag;
    logic                              id_match;
    logic [mcast_pkg::KSIZE_WIDTH-1:0] kernel_size;
    logic                              load_en;
    logic                              tap_en;
    logic                              cnt_restart;
    logic [mcast_pkg::ADDR_WIDTH-1:0]  tap_idx;
    logic                              last_tap;
    logic [mcast_pkg::DATA_WIDTH-1:0]  weight;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////
    tag_buffer u_tag (
        .clk      (clk),
        .rstn     (rstn),
        .bus_in   (bus_in),
        .tag      (tag),
        .tag_lock (tag_lock),
        .id_match (id_match)
    );

    cast_fsm u_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .bus_in      (bus_in),
        .id_match    (id_match),
        .tag_lock    (tag_lock),
        .last_tap    (last_tap),
        .kernel_size (kernel_size),
        .load_en     (load_en),
        .tap_en      (tap_en),
        .cnt_restart (cnt_restart),
        .pe_ready    (pe_ready)
    );

    // Steps on weight loads and on multicast ifmap words
    tap_counter u_cnt (
        .clk         (clk),
        .rstn        (rstn),
        .kernel_size (kernel_size),
        .restart     (cnt_restart),
        .step        (load_en | tap_en),
        .tap_idx     (tap_idx),
        .last_tap    (last_tap)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////
    weight_buffer u_wbuf (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (load_en),
        .wr_data (bus_in.data),
        .addr    (tap_idx),       // Same index for load and run
        .rd_en   (tap_en),
        .weight  (weight)
    );

    mac_accum u_mac (
        .clk          (clk),
        .rstn         (rstn),
        .bus_in       (bus_in),
        .id_match     (id_match),
        .tap_en       (tap_en),
        .last_tap     (last_tap),
        .weight       (weight),
        .tag          (tag),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* verification/pe_multicast_props.sv */
`timescale 1ns/1ns

module pe_multicast_props (
    input logic                             clk,
    input logic                             rstn,
    input logic                             tap_en,
    input logic                             last_tap,
    input logic [mcast_pkg::ADDR_WIDTH-1:0] tap_idx,
    input logic                             cnt_restart,
    input logic                             result_valid,
    input logic                             tag_lock,
    input mcast_pkg::cast_state_e           state
);

    int prop_fails = 0;   // Read by the testbench monitor

    // Pulse only three edges after a last-tap multicast was sampled
    result_after_last: assert property (@(posedge clk) disable iff (!rstn)
        result_valid |-> $past(tap_en && last_tap, 3))
    else begin
        $error("result_valid without a last-tap multicast three edges earlier");
        prop_fails++;
    end

    // Every closed window gives its pulse
    last_gives_result: assert property (@(posedge clk) disable iff (!rstn)
        (tap_en && last_tap) |-> ##3 result_valid)
    else begin
        $error("last-tap multicast gave no result_valid");
        prop_fails++;
    end

    // S_RUN only reachable through matching filter words
    run_needs_lock: assert property (@(posedge clk) disable iff (!rstn)
        (state == mcast_pkg::S_RUN) |-> tag_lock)
    else begin
        $error("S_RUN reached while tag_lock low");
        prop_fails++;
    end

    // Outside S_LOAD only multicast words move the tap counter
    load_only_in_load: assert property (@(posedge clk) disable iff (!rstn)
        (state != mcast_pkg::S_LOAD && !tap_en && !cnt_restart) |=> $stable(tap_idx))
    else begin
        $error("tap counter stepped outside S_LOAD without a multicast");
        prop_fails++;
    end

endmodule

/* verification/tb_pe_multicast.sv */
`timescale 1ns/1ns

module tb_pe_multicast;

    localparam int TIMEOUT = 50;                       // Cycles per wait loop
    localparam logic [mcast_pkg::ID_WIDTH-1:0] TAG = 3'd5;

    // Expected DUT levels for one bus cycle
    typedef struct packed {
        logic                             res_v;
        logic [mcast_pkg::ID_WIDTH-1:0]   tag;
        logic [mcast_pkg::PSUM_WIDTH-1:0] psum;
        logic                             ready;
        logic                             lock;
    } exp_t;

    logic                   clk;
    logic                   rstn;
    mcast_pkg::bus_pkt_t    bus_in;
    logic                   result_valid;
    mcast_pkg::result_pkt_t result;
    logic                   tag_lock;
    logic                   pe_ready;

    integer seed;
    string  test_name;
    exp_t   exp_pipe [4];   // [1] level checks, [3] result checks
    int     n_expected;
    int     n_seen;
    // Reference model state
    logic [mcast_pkg::ID_WIDTH-1:0]    m_tag;
    logic                              m_lock;
    mcast_pkg::cast_state_e            m_state;
    logic [mcast_pkg::KSIZE_WIDTH-1:0] m_ksize;
    int                                m_tap;
    logic [mcast_pkg::DATA_WIDTH-1:0]  m_w [mcast_pkg::MAX_KERNEL];
    logic                              m_in_win;
    logic                              m_seed_vld;
    logic signed [mcast_pkg::PSUM_WIDTH-1:0] m_seed;
    logic signed [mcast_pkg::PSUM_WIDTH-1:0] m_acc;

    pe_multicast_top DUT (.*);

    bind pe_multicast_top pe_multicast_props u_props (
        .clk (clk), .rstn (rstn), .tap_en (tap_en), .last_tap (last_tap),
        .tap_idx (tap_idx), .cnt_restart (cnt_restart),
        .result_valid (result_valid), .tag_lock (tag_lock), .state (u_fsm.state)
    );

    always #20 clk = ~clk;    // 40 ns period

    ////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////
    task automatic fail_stop();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_mismatch(input string what, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
        $display("CHECK FAILED test=%s %s expected=0x%0h actual=0x%0h",
                 test_name, what, exp_v, act_v);
        fail_stop();
    endtask

    task automatic plain_failure(input string why);
        $display("ERROR in test %s: %s", test_name, why);
        fail_stop();
    endtask

    ////////////////////////////////////////
    // Reference model, one bus packet
    ////////////////////////////////////////
    task automatic model_step(input mcast_pkg::bus_op_e op,
                              input logic [mcast_pkg::ID_WIDTH-1:0] id,
                              input logic [mcast_pkg::DATA_WIDTH-1:0] data,
                              output exp_t e);
        logic match;
        e = '0;
        match = m_lock && (id == m_tag);   // Tag before this packet
        case (op)
            mcast_pkg::OP_FLUSH_TAG: begin
                m_tag  = data[mcast_pkg::ID_WIDTH-1:0];
                m_lock = 1'b1;
            end
            mcast_pkg::OP_FLUSH_KERNEL: begin
                m_ksize  = data[mcast_pkg::KSIZE_WIDTH-1:0];
                m_tap    = 0;
                m_state  = mcast_pkg::S_LOAD;
                m_in_win = 1'b0;            // Open window dropped
            end
            mcast_pkg::OP_FLTR: if (match && m_state == mcast_pkg::S_LOAD) begin
                m_w[m_tap] = data;
                if (m_tap == m_ksize - 1) begin
                    m_tap   = 0;
                    m_state = mcast_pkg::S_RUN;
                end else begin
                    m_tap++;
                end
            end
            mcast_pkg::OP_PSUM: if (match && m_state != mcast_pkg::S_UNCONF) begin
                m_seed     = $signed(data);     // Sign-extended
                m_seed_vld = 1'b1;
            end
            mcast_pkg::OP_IFMAP: if (match && m_state == mcast_pkg::S_RUN) begin
                if (!m_in_win) begin
                    m_acc      = m_seed_vld ? m_seed : '0;
                    m_seed_vld = 1'b0;
                end
                m_acc = m_acc + $signed(data) * $signed(m_w[m_tap]);
                if (m_tap == m_ksize - 1) begin
                    e.res_v  = 1'b1;
                    e.tag    = m_tag;
                    e.psum   = m_acc;
                    m_tap    = 0;
                    m_in_win = 1'b0;
                    n_expected++;
                end else begin
                    m_tap++;
                    m_in_win = 1'b1;
                end
            end
            default: ;
        endcase
        e.ready = (m_state == mcast_pkg::S_RUN) && m_lock;
        e.lock  = m_lock;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    function automatic logic [mcast_pkg::DATA_WIDTH-1:0] rnd16();
        rnd16 = $random(seed);
    endfunction

    // One packet per cycle, returns at the following negedge
    task automatic drive_pkt(input mcast_pkg::bus_op_e op,
                             input logic [mcast_pkg::ID_WIDTH-1:0] id,
                             input logic [mcast_pkg::DATA_WIDTH-1:0] data);
        exp_t e;
        @(posedge clk);
        bus_in <= '{op: op, id: id, data: data};
        model_step(op, id, data, e);
        exp_pipe[0] <= e;
        exp_pipe[1] <= exp_pipe[0];
        exp_pipe[2] <= exp_pipe[1];
        exp_pipe[3] <= exp_pipe[2];
        @(negedge clk);
        if (result_valid === 1'b1) begin
            n_seen++;
        end
    endtask

    task automatic idle();
        drive_pkt(mcast_pkg::OP_NONE, '0, '0);
    endtask

    task automatic send_window(input int n, input bit mixed);
        for (int i = 0; i < n; i++) begin
            if (mixed) begin
                drive_pkt(mcast_pkg::OP_IFMAP, TAG ^ 3'd2, rnd16()); // Other column
            end
            drive_pkt(mcast_pkg::OP_IFMAP, TAG, rnd16());
        end
    endtask

    task automatic load_kernel(input int ksize);
        drive_pkt(mcast_pkg::OP_FLUSH_KERNEL, 3'd0, ksize[15:0]);
        for (int i = 0; i < ksize; i++) begin
            drive_pkt(mcast_pkg::OP_FLTR, TAG ^ 3'd1, rnd16()); // Must not advance
            drive_pkt(mcast_pkg::OP_FLTR, TAG, rnd16());
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (pe_ready !== 1'b1) begin
            if (cycles == TIMEOUT) plain_failure("pe_ready did not rise");
            idle();
            cycles++;
        end
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (n_seen < n_expected) begin
            if (cycles == TIMEOUT) plain_failure("result_valid did not arrive");
            idle();
            cycles++;
        end
    endtask

    ////////////////////////////////////////
    // Cycle monitor against the model
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (rstn) begin
            assert (DUT.u_props.prop_fails == 0) else plain_failure("bound property failed");
            assert (pe_ready === exp_pipe[1].ready)
                else value_mismatch("pe_ready", exp_pipe[1].ready, pe_ready);
            assert (tag_lock === exp_pipe[1].lock)
                else value_mismatch("tag_lock", exp_pipe[1].lock, tag_lock);
            assert (result_valid === exp_pipe[3].res_v)
                else value_mismatch("result_valid", exp_pipe[3].res_v, result_valid);
            if (exp_pipe[3].res_v) begin
                assert (result.psum === exp_pipe[3].psum)
                    else value_mismatch("psum", exp_pipe[3].psum, result.psum);
                assert (result.tag === exp_pipe[3].tag)
                    else value_mismatch("tag", exp_pipe[3].tag, result.tag);
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        bus_in     = '0;
        seed       = 32'h3a83220d;
        n_expected = 0;
        n_seen     = 0;
        m_lock     = 1'b0;
        m_state    = mcast_pkg::S_UNCONF;
        m_ksize    = '0;
        m_tap      = 0;
        m_in_win   = 1'b0;
        m_seed_vld = 1'b0;
        for (int i = 0; i < 4; i++) exp_pipe[i] = '0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        test_name = "reset_idle";
        idle();
        assert (!result_valid && !tag_lock && !pe_ready)
            else plain_failure("outputs not low after reset");
        drive_pkt(mcast_pkg::OP_IFMAP, 3'd0, rnd16());   // No tag yet
        drive_pkt(mcast_pkg::OP_IFMAP, TAG, rnd16());
        drive_pkt(mcast_pkg::OP_PSUM, TAG, rnd16());
        repeat (4) idle();

        test_name = "load_k3";
        drive_pkt(mcast_pkg::OP_FLUSH_TAG, 3'd7, {13'd0, TAG});
        drive_pkt(mcast_pkg::OP_FLTR, TAG, rnd16());     // Ignored, no kernel
        drive_pkt(mcast_pkg::OP_PSUM, TAG, rnd16());     // Ignored, no kernel
        drive_pkt(mcast_pkg::OP_IFMAP, TAG, rnd16());
        load_kernel(3);
        wait_ready();

        test_name = "window_mixed_ids";
        drive_pkt(mcast_pkg::OP_FLTR, TAG, rnd16());     // Ignored while running
        send_window(3, 1'b1);
        wait_results();

        test_name = "psum_seed_once";
        drive_pkt(mcast_pkg::OP_PSUM, TAG, rnd16());
        send_window(3, 1'b0);
        idle();
        send_window(3, 1'b0);                            // Starts from zero
        wait_results();

        test_name = "back_to_back";
        send_window(3, 1'b0);
        send_window(3, 1'b0);
        wait_results();

        test_name = "reload_k5";
        send_window(2, 1'b0);                            // Aborted by reload
        load_kernel(5);
        wait_ready();
        drive_pkt(mcast_pkg::OP_PSUM, TAG, rnd16());
        send_window(5, 1'b1);
        send_window(5, 1'b0);
        wait_results();
        repeat (4) idle();
        assert (n_seen == n_expected)
            else value_mismatch("result count", n_expected, n_seen);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* pe_multicast_top.f */
rtl/mcast_pkg.sv
rtl/tag_buffer.sv
rtl/weight_buffer.sv
rtl/tap_counter.sv
rtl/cast_fsm.sv
rtl/mac_accum.sv
rtl/pe_multicast_top.sv
verification/pe_multicast_props.sv
verification/tb_pe_multicast.sv

/* Bender.yml */
package:
  name: pe_multicast

sources:
  - rtl/mcast_pkg.sv
  - rtl/tag_buffer.sv
  - rtl/weight_buffer.sv
  - rtl/tap_counter.sv
  - rtl/cast_fsm.sv
  - rtl/mac_accum.sv
  - rtl/pe_multicast_top.sv
  - target: simulation
    files:
      - verification/pe_multicast_props.sv
      - verification/tb_pe_multicast.sv
